// File: compile.f
+incdir+include
hw/isa_pkg.sv
hw/alu_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu_exec.sv
hw/result_stage.sv
hw/exec_core.sv
test/tb_exec_core.sv

// File: Makefile
# Verilator build and run for the execution core testbench

LOG := run.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module tb_exec_core -Mdir obj_dir

run: compile
	-./obj_dir/Vtb_exec_core > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: test/tb_exec_core.sv
`include "core_params.svh"

module tb_exec_core
    import isa_pkg::*;
();

    localparam int DW       = `CORE_DATA_W;
    localparam int AW       = `CORE_REG_AW;
    localparam int N_ARITH  = 200;
    localparam int N_SHIFT  = 82;                   // Amounts 0 to 40, both directions
    localparam int N_BYPASS = 100;
    localparam int N_FLAG   = 150;
    localparam int N_NOP    = 100;
    localparam int GAP      = 4;
    localparam int N_CYCLES = 4 + 8 + N_ARITH + 3 * N_SHIFT + 2 * N_BYPASS + N_FLAG + N_NOP
                            + 6 * GAP;

    typedef struct {
        int            due;
        logic          wb;
        logic [AW-1:0] addr;
        logic [DW-1:0] data;
        logic          fl;
        logic          br;
        logic [DW-1:0] target;
        string         name;
    } expect_t;

    logic          clock;
    logic          arst_n;
    logic          instr_valid;
    instr_u        instr;
    logic          wb_valid;
    logic [AW-1:0] wb_addr;
    logic [DW-1:0] wb_data;
    logic          flag;
    logic          branch_taken;
    logic [DW-1:0] branch_target;

    logic [DW-1:0] model_regs [`CORE_REG_N];
    logic          model_flag;
    expect_t       pending [$];
    int            neg_cycle;
    string         test_name;

    logic          exp_wb;
    logic [AW-1:0] exp_addr;
    logic [DW-1:0] exp_data;
    logic          exp_flag;
    logic          exp_br;
    logic [DW-1:0] exp_target;
    string         exp_name;

    exec_core dut_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .flag          (flag),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial
    begin
        #((N_CYCLES + 100) * 4);
        $display("Watchdog expired before the test sequence finished");
        $display("TEST FAILED");
        $fatal(1, "Timeout");
    end

    task automatic report_mismatch(input string what, input logic [DW-1:0] exp_val,
                                   input logic [DW-1:0] act_val);
        $display("ERROR %s %s: expected %h, actual %h", exp_name, what, exp_val, act_val);
        $display("TEST FAILED");
        $fatal(1, "Output mismatch");
    endtask

    a_wb_valid: assert property (@(posedge clock) disable iff (!arst_n) wb_valid == exp_wb)
        else report_mismatch("wb_valid", DW'(exp_wb), DW'($sampled(wb_valid)));
    a_wb_addr: assert property (@(posedge clock) disable iff (!arst_n)
                                exp_wb |-> wb_addr == exp_addr)
        else report_mismatch("wb_addr", DW'(exp_addr), DW'($sampled(wb_addr)));
    a_wb_data: assert property (@(posedge clock) disable iff (!arst_n)
                                exp_wb |-> wb_data == exp_data)
        else report_mismatch("wb_data", exp_data, $sampled(wb_data));
    a_flag: assert property (@(posedge clock) disable iff (!arst_n) flag == exp_flag)
        else report_mismatch("flag", DW'(exp_flag), DW'($sampled(flag)));
    a_branch: assert property (@(posedge clock) disable iff (!arst_n) branch_taken == exp_br)
        else report_mismatch("branch_taken", DW'(exp_br), DW'($sampled(branch_taken)));
    a_target: assert property (@(posedge clock) disable iff (!arst_n)
                               exp_br |-> branch_target == exp_target)
        else report_mismatch("branch_target", exp_target, $sampled(branch_target));

    function automatic logic [DW-1:0] shift_ones(input logic [DW-1:0] a,
                                                 input logic [DW-1:0] amt, input logic left);
        logic [DW-1:0] r;
        r = a;
        if (amt >= 32)
            return '1;
        for (int i = 0; i < int'(amt); i++)
            r = left ? {r[DW-2:0], 1'b1} : {1'b1, r[DW-1:1]};   // One bit at a time
        return r;
    endfunction

    function automatic logic [AW-1:0] rand_reg();
        return AW'($urandom_range(`CORE_REG_N - 1));
    endfunction

    function automatic opcode_e rand_undefined_op();
        logic [6:0] code;
        code = 7'($urandom_range(127));
        while (code inside {[7'd0:7'd5], [7'd8:7'd11], 7'd14})
            code = 7'($urandom_range(127));
        return opcode_e'(code);
    endfunction

    // Pulses issued two cycles ago become the expected outputs of this cycle
    task automatic apply_due();
        expect_t rec;
        exp_wb = 1'b0;
        exp_br = 1'b0;
        if (pending.size() > 0 && pending[0].due == neg_cycle)
        begin
            rec        = pending.pop_front();
            exp_wb     = rec.wb;
            exp_addr   = rec.addr;
            exp_data   = rec.data;
            exp_flag   = rec.fl;
            exp_br     = rec.br;
            exp_target = rec.target;
            exp_name   = rec.name;
        end
    endtask

    task automatic drive_cycle(input logic valid, input instr_u word);
        @(negedge clock);
        neg_cycle++;
        apply_due();
        instr_valid = valid;
        instr       = word;
    endtask

    task automatic step(input instr_u word, input expect_t rec);
        drive_cycle(1'b1, word);
        rec.due = neg_cycle + 2;
        pending.push_back(rec);
    endtask

    task automatic idle();
        drive_cycle(1'b0, '0);
    endtask

    task automatic issue_reg(input opcode_e opc, input logic [AW-1:0] rd,
                             input logic [AW-1:0] rs1, input logic [AW-1:0] rs2);
        instr_u        word;
        expect_t       rec;
        logic [DW-1:0] a;
        logic [DW-1:0] b;
        a               = model_regs[rs1];
        b               = model_regs[rs2];
        word.r.opcode   = opc;
        word.r.rd       = rd;
        word.r.rs1      = rs1;
        word.r.rs2      = rs2;
        word.r.unused   = REG_PAD_W'($urandom);
        rec.addr        = rd;
        rec.data        = '0;
        rec.br          = 1'b0;
        rec.name        = test_name;
        case (opc)
            OP_ADD:  rec.data = a + b;
            OP_SUB:  rec.data = a - b;
            OP_SHL:  rec.data = shift_ones(a, b, 1'b1);
            OP_SHR:  rec.data = shift_ones(a, b, 1'b0);
            OP_MOV:  rec.data = a;
            OP_CEQ:  model_flag = (a == b);
            OP_CLT:  model_flag = (a < b);
            OP_CGT:  model_flag = (a > b);
            OP_FNOT: model_flag = !model_flag;
            OP_BRF:  rec.br = model_flag;
            default: rec.data = '0;
        endcase
        rec.wb     = opc inside {OP_ADD, OP_SUB, OP_SHL, OP_SHR, OP_MOV};
        rec.target = model_regs[`CORE_LINK_REG];
        rec.fl     = model_flag;
        if (rec.wb)
            model_regs[rd] = rec.data;
        step(word, rec);
    endtask

    task automatic issue_imm(input logic [AW-1:0] rd, input logic high, input logic [15:0] imm);
        instr_u        word;
        expect_t       rec;
        logic [DW-1:0] old;
        old           = model_regs[rd];
        word.i.opcode = OP_LDI;
        word.i.rd     = rd;
        word.i.high   = high;
        word.i.imm    = imm;
        rec.wb        = 1'b1;
        rec.addr      = rd;
        rec.data      = high ? {imm, old[15:0]} : {old[31:16], imm};
        rec.fl        = model_flag;
        rec.br        = 1'b0;
        rec.target    = '0;
        rec.name      = test_name;
        model_regs[rd] = rec.data;
        step(word, rec);
    endtask

    task automatic issue_random_arith();
        case ($urandom_range(3))
            0:       issue_reg(OP_ADD, rand_reg(), rand_reg(), rand_reg());
            1:       issue_reg(OP_SUB, rand_reg(), rand_reg(), rand_reg());
            2:       issue_reg(OP_MOV, rand_reg(), rand_reg(), rand_reg());
            default: issue_imm(rand_reg(), 1'($urandom_range(1)), 16'($urandom));
        endcase
    endtask

    initial
    begin
        logic [AW-1:0] sreg;
        logic [AW-1:0] dst;
        void'($urandom(75599));
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        neg_cycle   = 0;
        model_flag  = 1'b0;
        exp_wb      = 1'b0;
        exp_addr    = '0;
        exp_data    = '0;
        exp_flag    = 1'b0;
        exp_br      = 1'b0;
        exp_target  = '0;
        test_name   = "reset";
        exp_name    = "reset";
        for (int i = 0; i < `CORE_REG_N; i++)
            model_regs[i] = '0;
        repeat (4) idle();
        arst_n = 1'b1;
        repeat (8) idle();                          // Quiet outputs after reset

        test_name = "arith";
        repeat (N_ARITH) issue_random_arith();
        repeat (GAP) idle();

        test_name = "shift";
        for (int i = 0; i < N_SHIFT; i++)
        begin
            sreg = rand_reg();
            issue_imm(sreg, 1'b0, 16'(i / 2));
            issue_imm(sreg, 1'b1, 16'h0);
            issue_reg((i % 2 == 1) ? OP_SHR : OP_SHL, rand_reg(), rand_reg(), sreg);
        end
        repeat (GAP) idle();

        test_name = "bypass";
        for (int i = 0; i < N_BYPASS; i++)
        begin
            dst = rand_reg();
            if ($urandom_range(1) == 0)
                issue_reg(OP_ADD, dst, rand_reg(), rand_reg());
            else
                issue_imm(dst, 1'($urandom_range(1)), 16'($urandom));
            if ($urandom_range(1) == 0)
                issue_reg(OP_SUB, rand_reg(), dst, rand_reg());
            else
                issue_reg(OP_ADD, rand_reg(), rand_reg(), dst);
        end
        repeat (GAP) idle();

        test_name = "flag_branch";
        for (int i = 0; i < N_FLAG; i++)
        begin
            dst  = rand_reg();
            sreg = ($urandom_range(2) == 0) ? dst : rand_reg();   // Equal operands now and then
            case ($urandom_range(6))
                0:       issue_reg(OP_CEQ, rand_reg(), dst, sreg);
                1:       issue_reg(OP_CLT, rand_reg(), dst, sreg);
                2:       issue_reg(OP_CGT, rand_reg(), dst, sreg);
                3:       issue_reg(OP_FNOT, rand_reg(), dst, sreg);
                4:       issue_reg(OP_BRF, rand_reg(), dst, sreg);
                5:       issue_imm(AW'(`CORE_LINK_REG), 1'($urandom_range(1)), 16'($urandom));
                default: issue_random_arith();
            endcase
        end
        repeat (GAP) idle();

        test_name = "noop";
        for (int i = 0; i < N_NOP; i++)
        begin
            if ($urandom_range(1) == 0)
                issue_reg(rand_undefined_op(), rand_reg(), rand_reg(), rand_reg());
            else
                issue_random_arith();
        end
        repeat (GAP) idle();

        @(posedge clock);
        #1;
        $display("TEST OK");
        $finish;
    end

endmodule

// File: hw/exec_core.sv
`include "core_params.svh"

module exec_core
    import isa_pkg::*;
    import alu_pkg::*;
(
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    instr_valid,
    input  instr_u                  instr,
    output logic                    wb_valid,
    output logic [`CORE_REG_AW-1:0] wb_addr,
    output logic [`CORE_DATA_W-1:0] wb_data,
    output logic                    flag,
    output logic                    branch_taken,
    output logic [`CORE_DATA_W-1:0] branch_target
);

    logic [`CORE_REG_AW-1:0]   rd_addr_a;
    logic [`CORE_REG_AW-1:0]   rd_addr_b;
    logic [`CORE_DATA_W-1:0]   rd_data_a;
    logic [`CORE_DATA_W-1:0]   rd_data_b;
    logic                      wr_en;
    logic [`CORE_REG_AW-1:0]   wr_addr;
    logic [`CORE_DATA_W-1:0]   wr_data;

    logic                      dec_valid;
    alu_op_e                   dec_op;
    logic [`CORE_REG_AW-1:0]   dec_rd;
    logic [`CORE_DATA_W-1:0]   dec_a;
    logic [`CORE_DATA_W-1:0]   dec_b;
    logic [`CORE_DATA_W/2-1:0] dec_imm;
    logic                      dec_high;

    logic                      ex_wr;
    logic [`CORE_REG_AW-1:0]   ex_rd;
    logic [`CORE_DATA_W-1:0]   ex_data;
    logic                      ex_branch;
    logic [`CORE_DATA_W-1:0]   ex_target;

    instr_decoder decoder_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .ex_wr       (ex_wr),
        .ex_rd       (ex_rd),
        .ex_data     (ex_data),
        .dec_valid   (dec_valid),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_a       (dec_a),
        .dec_b       (dec_b),
        .dec_imm     (dec_imm),
        .dec_high    (dec_high)
    );

    reg_file regs_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    alu_exec alu_i (
        .clock     (clock),
        .arst_n    (arst_n),
        .dec_valid (dec_valid),
        .dec_op    (dec_op),
        .dec_rd    (dec_rd),
        .dec_a     (dec_a),
        .dec_b     (dec_b),
        .dec_imm   (dec_imm),
        .dec_high  (dec_high),
        .ex_wr     (ex_wr),
        .ex_rd     (ex_rd),
        .ex_data   (ex_data),
        .ex_branch (ex_branch),
        .ex_target (ex_target),
        .flag      (flag)
    );

    result_stage result_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .ex_wr         (ex_wr),
        .ex_rd         (ex_rd),
        .ex_data       (ex_data),
        .ex_branch     (ex_branch),
        .ex_target     (ex_target),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wb_valid      (wb_valid),
        .wb_addr       (wb_addr),
        .wb_data       (wb_data),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

endmodule

// File: hw/result_stage.sv
`include "core_params.svh"

module result_stage (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    ex_wr,
    input  logic [`CORE_REG_AW-1:0] ex_rd,
    input  logic [`CORE_DATA_W-1:0] ex_data,
    input  logic                    ex_branch,
    input  logic [`CORE_DATA_W-1:0] ex_target,
    output logic                    wr_en,
    output logic [`CORE_REG_AW-1:0] wr_addr,
    output logic [`CORE_DATA_W-1:0] wr_data,
    output logic                    wb_valid,
    output logic [`CORE_REG_AW-1:0] wb_addr,
    output logic [`CORE_DATA_W-1:0] wb_data,
    output logic                    branch_taken,
    output logic [`CORE_DATA_W-1:0] branch_target
);

    // One-cycle pulses
    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wb_valid     <= 1'b0;
            branch_taken <= 1'b0;
        end
        else
        begin
            wb_valid     <= ex_wr;
            branch_taken <= ex_branch;
        end
    end

    // Values hold between pulses
    always_ff @(posedge clock)
    begin
        if (ex_wr)
        begin
            wb_addr <= ex_rd;
            wb_data <= ex_data;
        end
        if (ex_branch)
        begin
            branch_target <= ex_target;
        end
    end

    assign wr_en   = wb_valid;
    assign wr_addr = wb_addr;
    assign wr_data = wb_data;

endmodule

// File: hw/alu_exec.sv
`include "core_params.svh"

module alu_exec
    import alu_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      dec_valid,
    input  alu_op_e                   dec_op,
    input  logic [`CORE_REG_AW-1:0]   dec_rd,
    input  logic [`CORE_DATA_W-1:0]   dec_a,
    input  logic [`CORE_DATA_W-1:0]   dec_b,
    input  logic [`CORE_DATA_W/2-1:0] dec_imm,
    input  logic                      dec_high,
    output logic                      ex_wr,
    output logic [`CORE_REG_AW-1:0]   ex_rd,
    output logic [`CORE_DATA_W-1:0]   ex_data,
    output logic                      ex_branch,
    output logic [`CORE_DATA_W-1:0]   ex_target,
    output logic                      flag
);

    localparam int HALF = `CORE_DATA_W / 2;

    logic [`CORE_DATA_W-1:0] result;
    logic                    flag_next;

    always_comb
    begin
        case (dec_op)
            ALU_ADD:  result = dec_a + dec_b;
            ALU_SUB:  result = dec_a - dec_b;
            ALU_SHL:  result = ~(~dec_a << dec_b);      // Ones shifted in
            ALU_SHR:  result = ~(~dec_a >> dec_b);
            ALU_LDI:
            begin
                if (dec_high)
                    result = {dec_imm, dec_a[HALF-1:0]};
                else
                    result = {dec_a[`CORE_DATA_W-1:HALF], dec_imm};
            end
            default:  result = dec_a;                   // PASS
        endcase
    end

    always_comb
    begin
        case (dec_op)
            ALU_CEQ:  flag_next = (dec_a == dec_b);
            ALU_CLT:  flag_next = (dec_a < dec_b);
            ALU_CGT:  flag_next = (dec_a > dec_b);
            ALU_FNOT: flag_next = ~flag;
            default:  flag_next = flag;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
            flag <= 1'b0;
        else if (dec_valid && sets_flag(dec_op))
            flag <= flag_next;
    end

    assign ex_wr     = dec_valid && writes_back(dec_op);
    assign ex_rd     = dec_rd;
    assign ex_data   = result;
    assign ex_branch = dec_valid && (dec_op == ALU_BRF) && flag;
    assign ex_target = dec_a;                           // Link register value

endmodule

// File: hw/reg_file.sv
`include "core_params.svh"

module reg_file (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic [`CORE_REG_AW-1:0] rd_addr_a,
    input  logic [`CORE_REG_AW-1:0] rd_addr_b,
    output logic [`CORE_DATA_W-1:0] rd_data_a,
    output logic [`CORE_DATA_W-1:0] rd_data_b,
    input  logic                    wr_en,
    input  logic [`CORE_REG_AW-1:0] wr_addr,
    input  logic [`CORE_DATA_W-1:0] wr_data
);

    logic [`CORE_DATA_W-1:0] regs [`CORE_REG_N];

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `CORE_REG_N; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-through so a reader two instructions behind sees the pending write
    assign rd_data_a = (wr_en && wr_addr == rd_addr_a) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (wr_en && wr_addr == rd_addr_b) ? wr_data : regs[rd_addr_b];

endmodule

// File: hw/instr_decoder.sv
`include "core_params.svh"

module instr_decoder
    import isa_pkg::*;
    import alu_pkg::*;
(
    input  logic                      clock,
    input  logic                      arst_n,
    input  logic                      instr_valid,
    input  instr_u                    instr,
    output logic [`CORE_REG_AW-1:0]   rd_addr_a,
    output logic [`CORE_REG_AW-1:0]   rd_addr_b,
    input  logic [`CORE_DATA_W-1:0]   rd_data_a,
    input  logic [`CORE_DATA_W-1:0]   rd_data_b,
    input  logic                      ex_wr,
    input  logic [`CORE_REG_AW-1:0]   ex_rd,
    input  logic [`CORE_DATA_W-1:0]   ex_data,
    output logic                      dec_valid,
    output alu_op_e                   dec_op,
    output logic [`CORE_REG_AW-1:0]   dec_rd,
    output logic [`CORE_DATA_W-1:0]   dec_a,
    output logic [`CORE_DATA_W-1:0]   dec_b,
    output logic [`CORE_DATA_W/2-1:0] dec_imm,
    output logic                      dec_high
);

    alu_op_e                 op_next;
    logic [`CORE_DATA_W-1:0] opnd_a;
    logic [`CORE_DATA_W-1:0] opnd_b;

    always_comb
    begin
        case (instr.r.opcode)
            OP_ADD:  op_next = ALU_ADD;
            OP_SUB:  op_next = ALU_SUB;
            OP_SHL:  op_next = ALU_SHL;
            OP_SHR:  op_next = ALU_SHR;
            OP_MOV:  op_next = ALU_PASS;
            OP_LDI:  op_next = ALU_LDI;
            OP_CEQ:  op_next = ALU_CEQ;
            OP_CLT:  op_next = ALU_CLT;
            OP_CGT:  op_next = ALU_CGT;
            OP_FNOT: op_next = ALU_FNOT;
            OP_BRF:  op_next = ALU_BRF;
            default: op_next = ALU_NOP;
        endcase
    end

    always_comb
    begin
        case (instr.r.opcode)
            OP_LDI:  rd_addr_a = instr.i.rd;                        // Merge into old rd value
            OP_BRF:  rd_addr_a = `CORE_REG_AW'(`CORE_LINK_REG);
            default: rd_addr_a = instr.r.rs1;
        endcase
    end

    assign rd_addr_b = instr.r.rs2;

    // Result still in execute overrides the file
    assign opnd_a = (ex_wr && ex_rd == rd_addr_a) ? ex_data : rd_data_a;
    assign opnd_b = (ex_wr && ex_rd == rd_addr_b) ? ex_data : rd_data_b;

    always_ff @(posedge clock or negedge arst_n)
    begin
        if (!arst_n)
        begin
            dec_valid <= 1'b0;
            dec_op    <= ALU_NOP;
        end
        else
        begin
            dec_valid <= instr_valid;
            dec_op    <= op_next;
        end
    end

    always_ff @(posedge clock)
    begin
        if (instr_valid)
        begin
            dec_rd   <= instr.r.rd;
            dec_a    <= opnd_a;
            dec_b    <= opnd_b;
            dec_imm  <= instr.i.imm;
            dec_high <= instr.i.high;
        end
    end

endmodule

// File: hw/alu_pkg.sv
package alu_pkg;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS,
        ALU_LDI,
        ALU_CEQ,
        ALU_CLT,
        ALU_CGT,
        ALU_FNOT,
        ALU_BRF
    } alu_op_e;

    // Operations that produce a register result
    function automatic logic writes_back(alu_op_e op);
        return op inside {ALU_ADD, ALU_SUB, ALU_SHL, ALU_SHR, ALU_PASS, ALU_LDI};
    endfunction

    // Operations that touch the flag
    function automatic logic sets_flag(alu_op_e op);
        return op inside {ALU_CEQ, ALU_CLT, ALU_CGT, ALU_FNOT};
    endfunction

endpackage

// File: hw/isa_pkg.sv
`include "core_params.svh"

package isa_pkg;

    localparam int OPC_W      = 7;
    localparam int REG_PAD_W  = `CORE_INSTR_W - OPC_W - 3 * `CORE_REG_AW;
    localparam int IMM_W      = `CORE_DATA_W / 2;

    typedef enum logic [OPC_W-1:0] {
        OP_ADD  = 7'd0,
        OP_SUB  = 7'd1,
        OP_SHL  = 7'd2,
        OP_SHR  = 7'd3,
        OP_MOV  = 7'd4,
        OP_LDI  = 7'd5,
        OP_CEQ  = 7'd8,
        OP_CLT  = 7'd9,
        OP_CGT  = 7'd10,
        OP_FNOT = 7'd11,
        OP_BRF  = 7'd14
    } opcode_e;                                     // Other codes act as no-ops

    typedef struct packed {
        opcode_e                 opcode;
        logic [`CORE_REG_AW-1:0] rd;
        logic [`CORE_REG_AW-1:0] rs1;
        logic [`CORE_REG_AW-1:0] rs2;
        logic [REG_PAD_W-1:0]    unused;
    } instr_reg_t;

    typedef struct packed {
        opcode_e                 opcode;
        logic [`CORE_REG_AW-1:0] rd;
        logic                    high;              // Selects upper half
        logic [IMM_W-1:0]        imm;
    } instr_imm_t;

    // Same 28 bits, two views
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

// File: include/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file sizing
`define CORE_DATA_W   32
`define CORE_REG_N    16
`define CORE_REG_AW   4

// Instruction word width
`define CORE_INSTR_W  28

// BRF takes its target from this register
`define CORE_LINK_REG 8

`endif
